/* all.f */
hw/tmac_pkg.sv
hw/tmac_result_if.sv
hw/tmac_insn_queue.sv
hw/tmac_lut.sv
hw/tmac_engine.sv
hw/tmac_result_queue.sv
hw/tmac_unit.sv
testbench/tmac_tb_assert.sv
testbench/tmac_tb.sv

/* hw/tmac_engine.sv */
/*
  Per-element engine of the multiply unit
  Bit-plane decomposition, table build, lookup and shifted accumulation
  Pushes each finished word with its id and address to the result queue
*/

`timescale 1ns/1ps
`default_nettype none

module tmac_engine #(
  parameter  int unsigned DataWidth      = tmac_pkg::DefDataWidth,
  parameter  int unsigned InsnQueueDepth = 4,
  localparam int unsigned NrWeights      = DataWidth / tmac_pkg::WeightBits,
  localparam int unsigned NrGroups       = NrWeights / tmac_pkg::GroupSize
) (
  input  wire                                          clk_i,
  input  wire                                          rst_ni,
  input  wire                                          issue_valid_i,
  input  tmac_pkg::tmac_insn_t                         issue_insn_i,
  output logic                                         issue_done_o,
  input  wire  [DataWidth-1:0]                         weight_i,
  input  wire                                          weight_valid_i,
  output logic                                         weight_ready_o,
  input  wire                                          act_valid_i,
  output logic                                         act_ready_o,
  output logic                                         lut_load_o,
  input  wire  [NrGroups-1:0][DataWidth-1:0]           lut_entry_i,
  output logic [NrGroups-1:0][tmac_pkg::GroupSize-1:0] lut_index_o,
  tmac_result_if.engine                                res
);

  localparam int unsigned PlaneWidth = $clog2(tmac_pkg::WeightBits);

  // Parameter checks at elaboration
  if (DataWidth % (tmac_pkg::GroupSize * tmac_pkg::WeightBits) != 0) begin : gen_width_check
    $error("DataWidth must be a multiple of GroupSize*WeightBits");
  end
  // More instructions in flight than ids would alias the done bits
  if (InsnQueueDepth > tmac_pkg::NrVInsn) begin : gen_depth_check
    $error("InsnQueueDepth exceeds the number of instruction ids");
  end

  typedef logic [NrGroups-1:0][tmac_pkg::GroupSize-1:0] plane_t;

  tmac_pkg::tmac_state_e        state_d, state_q;
  logic [PlaneWidth-1:0]        plane_d, plane_q;
  logic [tmac_pkg::VlWidth-1:0] elem_d, elem_q;
  logic [tmac_pkg::VlWidth-1:0] last_idx;
  logic                         last_elem;

  plane_t [tmac_pkg::WeightBits-1:0] planes_w, planes_q;
  logic   [DataWidth-1:0]            plane_sum;
  logic   [DataWidth-1:0]            acc_q;

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  // Plane b gathers bit b of every weight, GroupSize weights per index
  always_comb begin : p_decompose
    for (int unsigned b = 0; b < tmac_pkg::WeightBits; b++) begin
      for (int unsigned g = 0; g < NrGroups; g++) begin
        for (int unsigned j = 0; j < tmac_pkg::GroupSize; j++) begin
          planes_w[b][g][j] = weight_i[(g * tmac_pkg::GroupSize + j) * tmac_pkg::WeightBits + b];
        end
      end
    end
  end

  assign lut_index_o = planes_q[plane_q];

  // Sum of the group lookups for the current plane
  always_comb begin : p_plane_sum
    plane_sum = '0;
    for (int unsigned g = 0; g < NrGroups; g++) begin
      plane_sum = plane_sum + lut_entry_i[g];
    end
  end

  always_ff @(posedge clk_i) begin : p_payload
    if (weight_ready_o) begin
      planes_q <= planes_w;
    end
    if (act_ready_o) begin
      acc_q <= '0;
    end else if (state_q == tmac_pkg::LOOKUP) begin
      // Higher planes weigh by powers of two
      acc_q <= acc_q + (plane_sum << plane_q);
    end
  end

  // Element index in the low bits, destination register above
  assign res.id    = issue_insn_i.id;
  assign res.addr  = {issue_insn_i.vd, elem_q};
  assign res.wdata = acc_q;

  assign last_idx  = issue_insn_i.vl - 1'b1;
  assign last_elem = (elem_q == last_idx);

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////

  always_comb begin : p_fsm
    state_d        = state_q;
    plane_d        = plane_q;
    elem_d         = elem_q;
    weight_ready_o = 1'b0;
    act_ready_o    = 1'b0;
    lut_load_o     = 1'b0;
    res.push       = 1'b0;
    issue_done_o   = 1'b0;

    case (state_q)
      tmac_pkg::IDLE: begin
        if (issue_valid_i) begin
          elem_d  = '0;
          state_d = tmac_pkg::DECOMPOSE;
        end
      end
      tmac_pkg::DECOMPOSE: begin
        weight_ready_o = weight_valid_i;
        if (weight_valid_i) begin
          state_d = tmac_pkg::BUILD_LUT;
        end
      end
      tmac_pkg::BUILD_LUT: begin
        act_ready_o = act_valid_i;
        lut_load_o  = act_valid_i;
        if (act_valid_i) begin
          plane_d = '0;
          state_d = tmac_pkg::LOOKUP;
        end
      end
      tmac_pkg::LOOKUP: begin
        // Exactly one cycle per plane
        plane_d = plane_q + 1'b1;
        if (plane_q == PlaneWidth'(tmac_pkg::WeightBits - 1)) begin
          state_d = tmac_pkg::PUSH;
        end
      end
      tmac_pkg::PUSH: begin
        // Stall here while the result queue is full
        if (!res.full) begin
          res.push = 1'b1;
          if (last_elem) begin
            issue_done_o = 1'b1;
            state_d      = tmac_pkg::IDLE;
          end else begin
            elem_d  = elem_q + 1'b1;
            state_d = tmac_pkg::DECOMPOSE;
          end
        end
      end
      default: state_d = tmac_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
    if (!rst_ni) begin
      state_q <= tmac_pkg::IDLE;
      plane_q <= '0;
      elem_q  <= '0;
    end else begin
      state_q <= state_d;
      plane_q <= plane_d;
      elem_q  <= elem_d;
    end
  end

endmodule

`default_nettype wire

/* hw/tmac_insn_queue.sv */
/*
  Circular instruction queue
  Accept, issue and commit phases with separate pointers
  Commit is counted from register file grants, done pulses are one-hot
*/

`timescale 1ns/1ps
`default_nettype none

module tmac_insn_queue #(
  parameter int unsigned InsnQueueDepth = 4
) (
  input  wire                          clk_i,
  input  wire                          rst_ni,
  input  tmac_pkg::tmac_insn_t         op_i,
  input  wire                          op_valid_i,
  output logic                         op_ready_o,
  output logic                         issue_valid_o,
  output tmac_pkg::tmac_insn_t         issue_insn_o,
  input  wire                          issue_done_i,
  input  wire                          result_granted_i,
  output logic [tmac_pkg::NrVInsn-1:0] vinsn_done_o
);

  localparam int unsigned PtrWidth = (InsnQueueDepth > 1) ? $clog2(InsnQueueDepth) : 1;
  localparam int unsigned CntWidth = $clog2(InsnQueueDepth + 1);

  // Wrap a phase pointer at the end of the buffer
  function automatic logic [PtrWidth-1:0] next_pnt(input logic [PtrWidth-1:0] pnt);
    logic [PtrWidth-1:0] nxt;
    nxt = (pnt == PtrWidth'(InsnQueueDepth - 1)) ? '0 : pnt + 1'b1;
    return nxt;
  endfunction

  tmac_pkg::tmac_insn_t insn_q [InsnQueueDepth];

  logic [PtrWidth-1:0]          accept_pnt_q, issue_pnt_q, commit_pnt_q;
  // Issue count drops at issue done, commit count at the last grant
  logic [CntWidth-1:0]          issue_cnt_q, commit_cnt_q;
  logic [tmac_pkg::VlWidth-1:0] gnt_cnt_q;
  logic [tmac_pkg::NrVInsn-1:0] done_q;

  logic                         accept;
  logic                         commit_last;
  tmac_pkg::tmac_insn_t         commit_insn;
  logic [tmac_pkg::VlWidth-1:0] commit_last_idx;

  ////////////////////////////////////////
  // Accept and issue
  ////////////////////////////////////////

  // Queue slots stay taken until the results are committed
  assign op_ready_o = (commit_cnt_q != CntWidth'(InsnQueueDepth));
  // Other ops are acknowledged and dropped
  assign accept     = op_valid_i && op_ready_o && (op_i.op == tmac_pkg::OP_TMAC);

  assign issue_valid_o = (issue_cnt_q != '0);
  assign issue_insn_o  = insn_q[issue_pnt_q];

  ////////////////////////////////////////
  // Commit
  ////////////////////////////////////////

  assign commit_insn     = insn_q[commit_pnt_q];
  assign commit_last_idx = commit_insn.vl - 1'b1;
  // Grant that completes vl results of the oldest instruction
  assign commit_last     = result_granted_i && (gnt_cnt_q == commit_last_idx);

  assign vinsn_done_o = done_q;

  always_ff @(posedge clk_i) begin : p_buffer
    if (accept) begin
      insn_q[accept_pnt_q] <= op_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_control
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      gnt_cnt_q    <= '0;
      done_q       <= '0;
    end else begin
      if (accept) begin
        accept_pnt_q <= next_pnt(accept_pnt_q);
      end
      if (issue_done_i) begin
        issue_pnt_q <= next_pnt(issue_pnt_q);
      end
      // Net change of each occupancy count
      issue_cnt_q  <= issue_cnt_q + CntWidth'(accept) - CntWidth'(issue_done_i);
      commit_cnt_q <= commit_cnt_q + CntWidth'(accept) - CntWidth'(commit_last);

      done_q <= '0;
      if (commit_last) begin
        commit_pnt_q            <= next_pnt(commit_pnt_q);
        gnt_cnt_q               <= '0;
        done_q[commit_insn.id]  <= 1'b1;
      end else if (result_granted_i) begin
        gnt_cnt_q <= gnt_cnt_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/tmac_lut.sv */
/*
  Signed lookup table built from one activation word
  Entry i holds the plus-or-minus sum of the activation over index bits
  One combinational read port per weight group
*/

`timescale 1ns/1ps
`default_nettype none

module tmac_lut #(
  parameter  int unsigned DataWidth = tmac_pkg::DefDataWidth,
  localparam int unsigned NrWeights = DataWidth / tmac_pkg::WeightBits,
  localparam int unsigned NrGroups  = NrWeights / tmac_pkg::GroupSize
) (
  input  wire                                       clk_i,
  input  wire                                       rst_ni,
  input  wire                                       load_i,
  input  wire  [DataWidth-1:0]                      act_i,
  input  wire  [NrGroups-1:0][tmac_pkg::GroupSize-1:0] index_i,
  output logic [NrGroups-1:0][DataWidth-1:0]        entry_o
);

  logic [tmac_pkg::LutSize-1:0][DataWidth-1:0] lut_d, lut_q;

  // Set bit adds the activation, clear bit subtracts it
  always_comb begin : p_build
    for (int unsigned i = 0; i < tmac_pkg::LutSize; i++) begin
      lut_d[i] = '0;
      for (int unsigned j = 0; j < tmac_pkg::GroupSize; j++) begin
        if (((i >> j) & 1) != 0) begin
          lut_d[i] = lut_d[i] + act_i;
        end else begin
          lut_d[i] = lut_d[i] - act_i;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_table
    if (!rst_ni) begin
      lut_q <= '0;
    end else if (load_i) begin
      lut_q <= lut_d;
    end
  end

  // Parallel read with one index per group
  always_comb begin : p_read
    for (int unsigned g = 0; g < NrGroups; g++) begin
      entry_o[g] = lut_q[index_i[g]];
    end
  end

endmodule

`default_nettype wire

/* hw/tmac_pkg.sv */
/*
  Shared definitions of the table-lookup multiply unit
  Default widths, lookup table geometry and id sizes
  Instruction record, opcode and engine state encodings
*/

`default_nettype none

package tmac_pkg;

  // Default word width of weights, activations and results
  localparam int unsigned DefDataWidth = 32;

  // Weights packed into one lookup index
  localparam int unsigned GroupSize  = 4;
  // Bits per weight, one bit plane per bit
  localparam int unsigned WeightBits = 4;
  localparam int unsigned LutSize    = 2 ** GroupSize;

  // Instruction ids and register file addressing
  localparam int unsigned NrVInsn   = 8;
  localparam int unsigned VidWidth  = 3;
  localparam int unsigned VlWidth   = 8;
  localparam int unsigned VregWidth = 5;
  localparam int unsigned AddrWidth = VregWidth + VlWidth;

  typedef logic [VidWidth-1:0] vid_t;

  typedef enum logic [1:0] {
    OP_TMAC,
    OP_OTHER1,
    OP_OTHER2
  } tmac_op_e;

  // Element count vl runs from 1 to 255
  typedef struct packed {
    tmac_op_e               op;
    vid_t                   id;
    logic [VregWidth-1:0]   vd;
    logic [VlWidth-1:0]     vl;
  } tmac_insn_t;

  typedef enum logic [2:0] {
    IDLE,
    DECOMPOSE,
    BUILD_LUT,
    LOOKUP,
    PUSH
  } tmac_state_e;

endpackage

`default_nettype wire

/* hw/tmac_result_if.sv */
/*
  Result link from the engine to the result queue
  One finished result with its id and address per push
*/

`timescale 1ns/1ps
`default_nettype none

interface tmac_result_if #(
  parameter int unsigned DataWidth = tmac_pkg::DefDataWidth
);

  // Single cycle strobe raised only while full is low
  logic                           push;
  tmac_pkg::vid_t                 id;
  logic [tmac_pkg::AddrWidth-1:0] addr;
  logic [DataWidth-1:0]           wdata;
  // Queue holds two entries
  logic                           full;

  modport engine (output push, output id, output addr, output wdata, input full);
  modport queue  (input push, input id, input addr, input wdata, output full);

endinterface

`default_nettype wire

/* hw/tmac_result_queue.sv */
/*
  Two-entry result FIFO toward the register file
  Request while an entry is held, pop on grant
*/

`timescale 1ns/1ps
`default_nettype none

module tmac_result_queue #(
  parameter int unsigned DataWidth = tmac_pkg::DefDataWidth
) (
  input  wire                            clk_i,
  input  wire                            rst_ni,
  tmac_result_if.queue                   res,
  output logic                           result_req_o,
  output tmac_pkg::vid_t                 result_id_o,
  output logic [tmac_pkg::AddrWidth-1:0] result_addr_o,
  output logic [DataWidth-1:0]           result_wdata_o,
  input  wire                            result_gnt_i
);

  localparam int unsigned Depth = 2;

  tmac_pkg::vid_t                 id_q    [Depth];
  logic [tmac_pkg::AddrWidth-1:0] addr_q  [Depth];
  logic [DataWidth-1:0]           wdata_q [Depth];

  logic       rd_pnt_q, wr_pnt_q;
  logic [1:0] cnt_q;
  logic       pop;

  assign res.full     = (cnt_q == 2'(Depth));
  assign result_req_o = (cnt_q != '0);
  // Head entry drives the register file port
  assign result_id_o    = id_q[rd_pnt_q];
  assign result_addr_o  = addr_q[rd_pnt_q];
  assign result_wdata_o = wdata_q[rd_pnt_q];

  assign pop = result_req_o && result_gnt_i;

  always_ff @(posedge clk_i) begin : p_store
    if (res.push) begin
      id_q[wr_pnt_q]    <= res.id;
      addr_q[wr_pnt_q]  <= res.addr;
      wdata_q[wr_pnt_q] <= res.wdata;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_pointers
    if (!rst_ni) begin
      rd_pnt_q <= 1'b0;
      wr_pnt_q <= 1'b0;
      cnt_q    <= '0;
    end else begin
      if (res.push) begin
        wr_pnt_q <= ~wr_pnt_q;
      end
      if (pop) begin
        rd_pnt_q <= ~rd_pnt_q;
      end
      // Push and pop together keep the count
      cnt_q <= cnt_q + 2'(res.push) - 2'(pop);
    end
  end

endmodule

`default_nettype wire

/* hw/tmac_unit.sv */
/*
  Top level of the table-lookup multiply unit
  Instruction queue, engine, lookup table and result queue
*/

`timescale 1ns/1ps
`default_nettype none

module tmac_unit #(
  parameter  int unsigned DataWidth      = tmac_pkg::DefDataWidth,
  parameter  int unsigned InsnQueueDepth = 4,
  localparam int unsigned NrWeights      = DataWidth / tmac_pkg::WeightBits,
  localparam int unsigned NrGroups       = NrWeights / tmac_pkg::GroupSize
) (
  input  wire                            clk_i,
  input  wire                            rst_ni,
  // Instruction port
  input  tmac_pkg::tmac_insn_t           op_i,
  input  wire                            op_valid_i,
  output logic                           op_ready_o,
  // Operand streams
  input  wire  [DataWidth-1:0]           weight_i,
  input  wire                            weight_valid_i,
  output logic                           weight_ready_o,
  input  wire  [DataWidth-1:0]           act_i,
  input  wire                            act_valid_i,
  output logic                           act_ready_o,
  // Register file write port
  output logic                           result_req_o,
  output tmac_pkg::vid_t                 result_id_o,
  output logic [tmac_pkg::AddrWidth-1:0] result_addr_o,
  output logic [DataWidth-1:0]           result_wdata_o,
  input  wire                            result_gnt_i,
  output logic [tmac_pkg::NrVInsn-1:0]   vinsn_done_o
);

  tmac_pkg::tmac_insn_t                        issue_insn;
  logic                                        issue_valid, issue_done;
  logic                                        lut_load;
  logic [NrGroups-1:0][tmac_pkg::GroupSize-1:0] lut_index;
  logic [NrGroups-1:0][DataWidth-1:0]          lut_entry;
  logic                                        result_granted;

  tmac_result_if #(.DataWidth(DataWidth)) result_if ();

  // A grant counts only against a pending request
  assign result_granted = result_req_o && result_gnt_i;

  tmac_insn_queue #(.InsnQueueDepth(InsnQueueDepth)) insn_queue_i (
    .clk_i, .rst_ni, .op_i, .op_valid_i, .op_ready_o,
    .issue_valid_o(issue_valid), .issue_insn_o(issue_insn), .issue_done_i(issue_done),
    .result_granted_i(result_granted), .vinsn_done_o
  );

  tmac_engine #(.DataWidth(DataWidth), .InsnQueueDepth(InsnQueueDepth)) engine_i (
    .clk_i, .rst_ni,
    .issue_valid_i(issue_valid), .issue_insn_i(issue_insn), .issue_done_o(issue_done),
    .weight_i, .weight_valid_i, .weight_ready_o, .act_valid_i, .act_ready_o,
    .lut_load_o(lut_load), .lut_entry_i(lut_entry), .lut_index_o(lut_index),
    .res(result_if.engine)
  );

  tmac_lut #(.DataWidth(DataWidth)) lut_i (
    .clk_i, .rst_ni, .load_i(lut_load), .act_i,
    .index_i(lut_index), .entry_o(lut_entry)
  );

  tmac_result_queue #(.DataWidth(DataWidth)) result_queue_i (
    .clk_i, .rst_ni, .res(result_if.queue),
    .result_req_o, .result_id_o, .result_addr_o, .result_wdata_o, .result_gnt_i
  );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the multiply unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tmac_tb -o tmac_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/tmac_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "test passed"; then
  exit 0
fi
exit 1

/* testbench/tmac_tb.sv */
/*
  Testbench of the table-lookup multiply unit
  Random instructions and operand streams, random grants
  Reference model, scoreboard, watchdog
*/

`timescale 1ns/1ps
`default_nettype none

module tmac_tb;

  localparam int unsigned DataWidth = 32;
  localparam int unsigned Depth     = 4;
  localparam int          NrOps     = 24;
  // Grants withheld inside this cycle window
  localparam int          HoldStart = 40;
  localparam int          HoldEnd   = 160;

  logic                                  clk_i, rst_ni;
  tmac_pkg::tmac_insn_t                  op_i;
  logic                                  op_valid_i, op_ready_o;
  logic [DataWidth-1:0]                  weight_i, act_i;
  logic                                  weight_valid_i, weight_ready_o;
  logic                                  act_valid_i, act_ready_o;
  logic                                  result_req_o, result_gnt_i;
  tmac_pkg::vid_t                        result_id_o;
  logic [tmac_pkg::AddrWidth-1:0]        result_addr_o;
  logic [DataWidth-1:0]                  result_wdata_o;
  logic [tmac_pkg::NrVInsn-1:0]          vinsn_done_o;

  tmac_pkg::tmac_insn_t ops [NrOps];
  int                   op_idx, cycle, total_elems;
  logic [DataWidth-1:0] wq[$], aq[$];

  // Scoreboard queues filled by stimulus and drained by the checker
  tmac_pkg::vid_t                 exp_id_q[$], done_q[$];
  logic [tmac_pkg::AddrWidth-1:0] exp_addr_q[$];
  logic [DataWidth-1:0]           exp_data_q[$];
  bit                             exp_last_q[$];
  int                             outstanding, pending_done, consumed, granted;
  bit                             saw_full;

  tmac_unit #(.DataWidth(DataWidth), .InsnQueueDepth(Depth)) dut_i (.*);

  // Activation times the sum of 2*w_k - 15 over all weights modulo 2^32
  function automatic logic [DataWidth-1:0] tmac_ref(input logic [DataWidth-1:0] w,
                                                    input logic [DataWidth-1:0] a);
    int coef;
    coef = 0;
    for (int k = 0; k < DataWidth / 4; k++) begin
      coef = coef + 2 * int'(w[4*k +: 4]) - 15;
    end
    return a * DataWidth'(coef);
  endfunction

  // Zero, all-15 and random weight words
  function automatic logic [DataWidth-1:0] pick_weight();
    int mode;
    mode = $urandom % 8;
    if (mode == 0) return '0;
    if (mode == 1) return '1;
    return $urandom;
  endfunction

  // Small negative, small positive or full range activation
  function automatic logic [DataWidth-1:0] pick_act();
    int mode;
    mode = $urandom % 3;
    if (mode == 0) return -DataWidth'($urandom_range(1, 100));
    if (mode == 1) return DataWidth'($urandom_range(0, 100));
    return $urandom;
  endfunction

  task automatic value_error(input string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    $display("test failed");
    $fatal(1, "stopping on first error");
  endtask

  task automatic run_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    $display("test failed");
    $fatal(1, "stopping on first error");
  endtask

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  always @(posedge clk_i) begin : p_stim
    if (rst_ni) begin
      cycle = cycle + 1;
      if (weight_valid_i && weight_ready_o) void'(wq.pop_front());
      if (act_valid_i && act_ready_o) void'(aq.pop_front());
      // Queue operands and expected results of an accepted op
      if (op_valid_i && op_ready_o) begin
        if (op_i.op == tmac_pkg::OP_TMAC) begin
          for (int e = 0; e < int'(op_i.vl); e++) begin
            logic [DataWidth-1:0] w, a;
            w = pick_weight();
            a = pick_act();
            wq.push_back(w);
            aq.push_back(a);
            exp_id_q.push_back(op_i.id);
            exp_addr_q.push_back({op_i.vd, tmac_pkg::VlWidth'(e)});
            exp_data_q.push_back(tmac_ref(w, a));
            exp_last_q.push_back(e == int'(op_i.vl) - 1);
          end
          done_q.push_back(op_i.id);
        end
        op_idx = op_idx + 1;
      end
      op_valid_i <= (op_idx < NrOps) && ($urandom % 3 != 0);
      if (op_idx < NrOps) op_i <= ops[op_idx];
      weight_valid_i <= (wq.size() > 0) && ($urandom % 4 != 0);
      weight_i       <= (wq.size() > 0) ? wq[0] : '0;
      act_valid_i    <= (aq.size() > 0) && ($urandom % 4 != 0);
      act_i          <= (aq.size() > 0) ? aq[0] : '0;
      // No grant right after a grant, so the request cannot vanish under it
      result_gnt_i <= !(cycle >= HoldStart && cycle < HoldEnd) && result_req_o
                      && !result_gnt_i && ($urandom % 2 != 0);
    end
  end

  ////////////////////////////////////////
  // Checker
  ////////////////////////////////////////

  always @(posedge clk_i) begin : p_check
    logic [tmac_pkg::NrVInsn-1:0] onehot;
    bit                           last;
    if (rst_ni) begin
      assert (op_ready_o == (outstanding < Depth))
        else value_error($sformatf("op_ready_o is %0b with %0d outstanding",
                                   op_ready_o, outstanding));
      if (!op_ready_o) saw_full = 1'b1;
      if (weight_valid_i && weight_ready_o) consumed = consumed + 1;
      last = 1'b0;
      if (result_req_o && result_gnt_i) begin
        assert (exp_id_q.size() > 0)
          else run_error("a result was granted that no instruction asked for");
        assert (result_id_o == exp_id_q[0])
          else value_error($sformatf("id %0d, expected %0d", result_id_o, exp_id_q[0]));
        assert (result_addr_o == exp_addr_q[0])
          else value_error($sformatf("addr %h, expected %h", result_addr_o, exp_addr_q[0]));
        assert (result_wdata_o == exp_data_q[0])
          else value_error($sformatf("data %h, expected %h", result_wdata_o, exp_data_q[0]));
        last = exp_last_q[0];
        void'(exp_id_q.pop_front());
        void'(exp_addr_q.pop_front());
        void'(exp_data_q.pop_front());
        void'(exp_last_q.pop_front());
        granted = granted + 1;
      end
      // Two queued results plus one held in the engine
      assert (consumed - granted <= 3)
        else value_error($sformatf("%0d operands consumed ahead of grants", consumed - granted));
      // Done bit follows the last grant of its instruction by one cycle
      assert (pending_done == 0 || vinsn_done_o != '0)
        else run_error("no done pulse in the cycle after the last result of an instruction");
      if (vinsn_done_o != '0) begin
        assert (done_q.size() > 0 && pending_done > 0)
          else run_error("a done pulse came before the last result of its instruction");
        onehot = '0;
        onehot[done_q[0]] = 1'b1;
        assert (vinsn_done_o == onehot)
          else value_error($sformatf("done %b, expected %b", vinsn_done_o, onehot));
        void'(done_q.pop_front());
        pending_done = pending_done - 1;
      end
      if (last) pending_done = pending_done + 1;
      outstanding = outstanding - int'(last)
                    + int'(op_valid_i && op_ready_o && op_i.op == tmac_pkg::OP_TMAC);
    end
  end

  ////////////////////////////////////////
  // Sequence and watchdog
  ////////////////////////////////////////

  initial begin : p_main
    void'($urandom(47571));
    total_elems = 0;
    for (int i = 0; i < NrOps; i++) begin
      ops[i].op = ($urandom % 5 == 0) ? tmac_pkg::OP_OTHER1 : tmac_pkg::OP_TMAC;
      ops[i].id = tmac_pkg::VidWidth'(i % tmac_pkg::NrVInsn);
      ops[i].vd = tmac_pkg::VregWidth'($urandom);
      ops[i].vl = tmac_pkg::VlWidth'($urandom_range(1, 6));
      total_elems = total_elems + int'(ops[i].vl);
    end
    {op_i, op_valid_i, weight_i, weight_valid_i, act_i, act_valid_i, result_gnt_i} = '0;
    {op_idx, cycle, outstanding, pending_done, consumed, granted, saw_full} = '0;
    rst_ni = 1'b0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    while (op_idx < NrOps || exp_id_q.size() > 0 || done_q.size() > 0) begin
      @(posedge clk_i);
    end
    repeat (5) @(posedge clk_i);
    assert (saw_full) else run_error("the instruction queue never filled up");
    if (vinsn_done_o == '0 && pending_done == 0) begin
      $display("test passed");
    end else begin
      $display("Error: a done pulse is still pending at the end of the run");
      $display("test failed");
    end
    $finish;
  end

  initial begin : p_watchdog
    @(posedge rst_ni);
    repeat (total_elems * 60 + HoldEnd) @(posedge clk_i);
    $display("Error: the run did not finish in time");
    $display("test failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

/* testbench/tmac_tb_assert.sv */
/*
  Protocol assertions bound to the unit top level
  Grant only with request, stable request data, ready only with valid
*/

`timescale 1ns/1ps
`default_nettype none

module tmac_tb_assert #(
  parameter int unsigned DataWidth = 32
) (
  input wire                            clk_i,
  input wire                            rst_ni,
  input wire                            result_req_o,
  input wire                            result_gnt_i,
  input wire [tmac_pkg::VidWidth-1:0]   result_id_o,
  input wire [tmac_pkg::AddrWidth-1:0]  result_addr_o,
  input wire [DataWidth-1:0]            result_wdata_o,
  input wire                            weight_valid_i,
  input wire                            weight_ready_o,
  input wire                            act_valid_i,
  input wire                            act_ready_o
);

  // Register file may only grant a pending request
  a_gnt_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_gnt_i |-> result_req_o)
    else $error("grant seen without a request");

  // Head entry holds until it is granted
  a_req_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (result_req_o && !result_gnt_i) |=> (result_req_o && $stable(result_id_o)
      && $stable(result_addr_o) && $stable(result_wdata_o)))
    else $error("request dropped or changed before grant");

  a_weight_ready : assert property (@(posedge clk_i) disable iff (!rst_ni)
    weight_ready_o |-> weight_valid_i)
    else $error("weight ready without valid");

  a_act_ready : assert property (@(posedge clk_i) disable iff (!rst_ni)
    act_ready_o |-> act_valid_i)
    else $error("activation ready without valid");

endmodule

bind tmac_unit tmac_tb_assert #(.DataWidth(DataWidth)) assert_i (
  .clk_i(clk_i), .rst_ni(rst_ni),
  .result_req_o(result_req_o), .result_gnt_i(result_gnt_i),
  .result_id_o(result_id_o), .result_addr_o(result_addr_o),
  .result_wdata_o(result_wdata_o),
  .weight_valid_i(weight_valid_i), .weight_ready_o(weight_ready_o),
  .act_valid_i(act_valid_i), .act_ready_o(act_ready_o)
);

`default_nettype wire
